//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       ?= pipe_ctrl_tb
RTL_TOP   ?= pipe_ctrl_top
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ns --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- common/pipe_ctrl_pkg.sv
// pipeline control package with shared widths, decoded-entry layout and trap cause codes
package pipe_ctrl_pkg;

    localparam int QUEUE_DEPTH_DEFAULT = 4; // decoded-insn slots, power of two

    typedef logic [31:0] word_t;    // data or address word
    typedef logic [4:0]  regidx_t;  // x0 is hardwired zero
    typedef logic [4:0]  vregidx_t; // v0..v31

    // one decoded instruction waiting for execute
    typedef struct packed {
        word_t    pc;
        regidx_t  rs1;
        regidx_t  rs2;
        regidx_t  rd;
        logic     reg_write;   // writes rd
        logic     is_load;
        logic     is_csr_read;
        logic     is_vsetvl;   // blocks decode until execute retires it
        vregidx_t vs1;
        vregidx_t vs2;
        vregidx_t vd;
        logic     vs1_used;
        logic     vs2_used;
        logic     vreg_write;  // writes vd
    } queue_entry_t;

    // mcause numbering, listed highest priority first
    // code 0 reused as "no trap", insn misalignment is caught before the queue
    typedef enum logic [3:0] {
        cause_none        = 4'd0,
        cause_fault_load  = 4'd5,
        cause_mal_load    = 4'd4,
        cause_fault_store = 4'd7,
        cause_mal_store   = 4'd6,
        cause_illegal     = 4'd2,
        cause_breakpoint  = 4'd3,
        cause_env_call    = 4'd11
    } trap_cause_t;

endpackage

//--- common/stage_status_if.sv
// stage status bundle carrying execute and memory stage state into the hazard logic
`timescale 1ns/1ns

interface stage_status_if import pipe_ctrl_pkg::*; ();

    // execute stage
    word_t   ex_pc;
    logic    ex_valid;
    logic    ex_jump;
    logic    ex_branch;
    logic    ex_mispredict;    // resolved branch disagrees with prediction
    logic    ex_busy;          // multicycle op in flight
    logic    ex_vsetvl_done;   // vsetvl retired, vl/vtype now valid

    // memory stage
    logic    m_valid;
    word_t   m_pc;
    regidx_t m_rd;
    logic    m_reg_write;
    logic    m_dren;           // load
    logic    m_dwen;           // store
    logic    m_csr_read;
    logic    d_mem_busy;       // dcache not ready

    // exception flags from execute and memory
    logic    fault_l, mal_l, fault_s, mal_s;
    logic    illegal_insn, breakpoint, env;

    modport detect (
        input ex_valid, ex_jump, ex_branch, ex_mispredict,
        input m_valid, m_rd, m_reg_write, m_dren, m_dwen, m_csr_read, d_mem_busy
    );

    modport ctrl (input ex_busy, ex_vsetvl_done);

    modport trap (
        input ex_pc, m_pc,
        input fault_l, mal_l, fault_s, mal_s, illegal_insn, breakpoint, env
    );

endinterface

//--- hazard_unit/hazard_ctrl.sv
// stall and flush arbitration, turns detected hazards into pipeline controls
`timescale 1ns/1ns

module hazard_ctrl (
    input  logic            CLK,
    input  logic            nRST,
    stage_status_if.ctrl    status,
    input  logic            mem_use,
    input  logic            vreg_conflict,
    input  logic            branch_jump,
    input  logic            exception,
    input  logic            wait_dmem,
    input  logic            queue_full,
    input  logic            queue_wen,      // accepted decode write
    input  logic            wr_is_vsetvl,   // that write is a vsetvl
    output logic            npc_sel,
    output logic            stall_decode,
    output logic            flush_queue,
    output logic            stall_queue,
    output logic            ex_mem_stall,
    output logic            ex_mem_flush,
    output logic            suppress_data
);

    logic vsetvl_stall; // vsetvl issued, vl/vtype not yet known

    assign npc_sel       = branch_jump;            // take redirect target
    assign flush_queue   = exception || branch_jump; // control hazards
    assign suppress_data = exception;              // keep faulting access off the bus

    // decode holds on a full queue or pending vsetvl, never while flushing
    assign stall_decode = (queue_full || vsetvl_stall) && !flush_queue;

    // mem stage cannot advance
    assign ex_mem_stall = wait_dmem || vreg_conflict;

    // stall of a later stage stalls the head as well
    // busy execute yields to control hazards so the redirect is not lost
    assign stall_queue = ex_mem_stall
                       || (status.ex_busy && !flush_queue)
                       || mem_use;

    // bubble into mem whenever head is held but mem moves on
    assign ex_mem_flush = flush_queue || (stall_queue && !ex_mem_stall);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            vsetvl_stall <= 1'b0;
        end else if (flush_queue) begin
            vsetvl_stall <= 1'b0;          // vsetvl squashed
        end else if (status.ex_vsetvl_done) begin
            vsetvl_stall <= 1'b0;          // vl/vtype settled
        end else if (queue_wen && wr_is_vsetvl) begin
            vsetvl_stall <= 1'b1;
        end
    end

    // decode and flush are exclusive so a squashed slot is never refilled
    assert property (@(posedge CLK) disable iff (!nRST) !(stall_decode && flush_queue))
        else $error("stall_decode together with flush_queue");

    assert property (@(posedge CLK) disable iff (!nRST) npc_sel |-> flush_queue)
        else $error("redirect without queue flush");

endmodule

//--- hazard_unit/hazard_detect.sv
// hazard detection for the queue head, load-use, vector register and control hazards
`timescale 1ns/1ns

module hazard_detect import pipe_ctrl_pkg::*; (
    input  queue_entry_t         head,
    input  logic                 head_valid,
    stage_status_if.detect       status,
    input  logic                 exception,     // from trap_report
    output logic                 mem_use,
    output logic                 vreg_conflict,
    output logic                 branch_jump,
    output logic                 wait_dmem
);

    logic rs1_match, rs2_match;
    logic cannot_forward;
    logic dmem_access;
    logic vs1_clash, vs2_clash;

    // x0 never creates a dependency
    assign rs1_match = (head.rs1 == status.m_rd) && (status.m_rd != '0);
    assign rs2_match = (head.rs2 == status.m_rd) && (status.m_rd != '0);

    // load data and csr reads only exist at the end of mem
    assign cannot_forward = status.m_dren || status.m_csr_read;

    assign mem_use = head_valid && status.m_valid && status.m_reg_write
                   && cannot_forward && (rs1_match || rs2_match);

    // vd overlapping a live source of the same insn
    assign vs1_clash = head.vs1_used && (head.vd == head.vs1);
    assign vs2_clash = head.vs2_used && (head.vd == head.vs2);

    assign vreg_conflict = head_valid && head.vreg_write && (vs1_clash || vs2_clash);

    // redirect on jumps and on wrongly predicted branches only
    assign branch_jump = status.ex_valid
                       && (status.ex_jump || (status.ex_branch && status.ex_mispredict));

    assign dmem_access = status.m_dren || status.m_dwen;

    // faulting access is suppressed, so no point waiting on it
    assign wait_dmem = dmem_access && status.d_mem_busy && !exception;

endmodule

//--- hazard_unit/trap_report.sv
// trap reporting, picks the highest priority exception and registers cause and epc
`timescale 1ns/1ns

module trap_report import pipe_ctrl_pkg::*; (
    input  logic            CLK,
    input  logic            nRST,
    stage_status_if.trap    status,
    output logic            exception,     // any flag this cycle
    output logic            trap_valid,
    output trap_cause_t     trap_cause,
    output word_t           trap_epc
);

    trap_cause_t cause_next;
    logic        mem_cause;  // raised by the memory stage
    word_t       epc_next;

    // fixed priority, memory faults first
    always_comb begin
        cause_next = cause_none;
        if (status.fault_l)           cause_next = cause_fault_load;
        else if (status.mal_l)        cause_next = cause_mal_load;
        else if (status.fault_s)      cause_next = cause_fault_store;
        else if (status.mal_s)        cause_next = cause_mal_store;
        else if (status.illegal_insn) cause_next = cause_illegal;
        else if (status.breakpoint)   cause_next = cause_breakpoint;
        else if (status.env)          cause_next = cause_env_call;
    end

    assign exception = (cause_next != cause_none);
    assign mem_cause = status.fault_l || status.mal_l || status.fault_s || status.mal_s;
    assign epc_next  = mem_cause ? status.m_pc : status.ex_pc; // oldest faulting insn

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            trap_valid <= 1'b0;
            trap_cause <= cause_none;
        end else begin
            trap_valid <= exception;
            trap_cause <= cause_next;
        end
    end

    always_ff @(posedge CLK) begin
        trap_epc <= epc_next; // payload, qualified by trap_valid
    end

    assert property (@(posedge CLK) disable iff (!nRST) trap_valid |-> trap_cause != cause_none)
        else $error("trap_valid with no cause");

endmodule

//--- source/insn_queue.sv
// decoded instruction queue, circular FIFO between decode and execute with flush
`timescale 1ns/1ns

module insn_queue import pipe_ctrl_pkg::*; #(
    parameter int QUEUE_DEPTH = QUEUE_DEPTH_DEFAULT
) (
    input  logic         CLK,
    input  logic         nRST,
    input  logic         wr_en,      // decode push
    input  queue_entry_t wr_entry,
    input  logic         flush,      // drop everything at next edge
    input  logic         stall,      // execute not taking head
    output logic         full,
    output logic         head_valid,
    output queue_entry_t head
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1; // holds 0..QUEUE_DEPTH

    queue_entry_t mem [QUEUE_DEPTH]; // payload only

    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] count;
    logic push, pop;

    assign full       = (count == CNT_W'(QUEUE_DEPTH));
    assign head_valid = (count != '0);
    assign head       = mem[rd_ptr];

    // flush wins over a same-cycle write
    assign push = wr_en && !flush && !full;
    assign pop  = head_valid && !stall && !flush;

    always_ff @(posedge CLK) begin
        if (push) mem[wr_ptr] <= wr_entry;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;   // back to empty
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // idle or push+pop
            endcase
        end
    end

    // decode must honour stall_decode while the queue is full
    assert property (@(posedge CLK) disable iff (!nRST) !(wr_en && full && !flush))
        else $error("insn_queue write while full");

endmodule

//--- source/pipe_ctrl_top.sv
// pipeline control top, decoded-insn queue with hazard, stall/flush and trap logic
`timescale 1ns/1ns

module pipe_ctrl_top import pipe_ctrl_pkg::*; #(
    parameter int QUEUE_DEPTH = QUEUE_DEPTH_DEFAULT
) (
    input  logic        CLK,
    input  logic        nRST,
    // decode
    input  logic        dec_valid,
    input  word_t       dec_pc,
    input  regidx_t     dec_rs1,
    input  regidx_t     dec_rs2,
    input  regidx_t     dec_rd,
    input  logic        dec_reg_write,
    input  logic        dec_is_load,
    input  logic        dec_is_csr_read,
    input  logic        dec_is_vsetvl,
    input  vregidx_t    dec_vs1,
    input  vregidx_t    dec_vs2,
    input  vregidx_t    dec_vd,
    input  logic        dec_vs1_used,
    input  logic        dec_vs2_used,
    input  logic        dec_vreg_write,
    // execute status
    input  word_t       ex_pc,
    input  logic        ex_valid,
    input  logic        ex_jump,
    input  logic        ex_branch,
    input  logic        ex_mispredict,
    input  logic        ex_busy,
    input  logic        ex_vsetvl_done,
    // memory status
    input  logic        m_valid,
    input  word_t       m_pc,
    input  regidx_t     m_rd,
    input  logic        m_reg_write,
    input  logic        m_dren,
    input  logic        m_dwen,
    input  logic        m_csr_read,
    input  logic        d_mem_busy,
    // exception flags
    input  logic        fault_l,
    input  logic        mal_l,
    input  logic        fault_s,
    input  logic        mal_s,
    input  logic        illegal_insn,
    input  logic        breakpoint,
    input  logic        env,
    // head of queue toward execute
    output logic        head_valid,
    output word_t       head_pc,
    output regidx_t     head_rs1,
    output regidx_t     head_rs2,
    output regidx_t     head_rd,
    // controls
    output logic        npc_sel,
    output logic        stall_decode,
    output logic        flush_queue,
    output logic        stall_queue,
    output logic        ex_mem_stall,
    output logic        ex_mem_flush,
    output logic        suppress_data,
    // trap record
    output logic        trap_valid,
    output trap_cause_t trap_cause,
    output word_t       trap_epc
);

    stage_status_if status_if ();

    queue_entry_t dec_entry, head;
    logic queue_wen, queue_full;
    logic mem_use, vreg_conflict, branch_jump, exception, wait_dmem;

    assign dec_entry = '{
        pc: dec_pc, rs1: dec_rs1, rs2: dec_rs2, rd: dec_rd,
        reg_write: dec_reg_write, is_load: dec_is_load,
        is_csr_read: dec_is_csr_read, is_vsetvl: dec_is_vsetvl,
        vs1: dec_vs1, vs2: dec_vs2, vd: dec_vd,
        vs1_used: dec_vs1_used, vs2_used: dec_vs2_used, vreg_write: dec_vreg_write
    };

    assign queue_wen = dec_valid && !stall_decode; // decode handshake

    // stage status onto the bundle
    assign status_if.ex_pc          = ex_pc;
    assign status_if.ex_valid       = ex_valid;
    assign status_if.ex_jump        = ex_jump;
    assign status_if.ex_branch      = ex_branch;
    assign status_if.ex_mispredict  = ex_mispredict;
    assign status_if.ex_busy        = ex_busy;
    assign status_if.ex_vsetvl_done = ex_vsetvl_done;
    assign status_if.m_valid        = m_valid;
    assign status_if.m_pc           = m_pc;
    assign status_if.m_rd           = m_rd;
    assign status_if.m_reg_write    = m_reg_write;
    assign status_if.m_dren         = m_dren;
    assign status_if.m_dwen         = m_dwen;
    assign status_if.m_csr_read     = m_csr_read;
    assign status_if.d_mem_busy     = d_mem_busy;
    assign status_if.fault_l        = fault_l;
    assign status_if.mal_l          = mal_l;
    assign status_if.fault_s        = fault_s;
    assign status_if.mal_s          = mal_s;
    assign status_if.illegal_insn   = illegal_insn;
    assign status_if.breakpoint     = breakpoint;
    assign status_if.env            = env;

    assign head_pc  = head.pc;
    assign head_rs1 = head.rs1;
    assign head_rs2 = head.rs2;
    assign head_rd  = head.rd;

    insn_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
        .CLK, .nRST,
        .wr_en(queue_wen), .wr_entry(dec_entry),
        .flush(flush_queue), .stall(stall_queue),
        .full(queue_full), .head_valid, .head
    );

    hazard_detect u_detect (
        .head, .head_valid, .status(status_if.detect), .exception,
        .mem_use, .vreg_conflict, .branch_jump, .wait_dmem
    );

    hazard_ctrl u_ctrl (
        .CLK, .nRST, .status(status_if.ctrl),
        .mem_use, .vreg_conflict, .branch_jump, .exception, .wait_dmem,
        .queue_full, .queue_wen, .wr_is_vsetvl(dec_is_vsetvl),
        .npc_sel, .stall_decode, .flush_queue, .stall_queue,
        .ex_mem_stall, .ex_mem_flush, .suppress_data
    );

    trap_report u_trap (
        .CLK, .nRST, .status(status_if.trap),
        .exception, .trap_valid, .trap_cause, .trap_epc
    );

endmodule

//--- src.f
common/pipe_ctrl_pkg.sv
common/stage_status_if.sv
source/insn_queue.sv
hazard_unit/hazard_detect.sv
hazard_unit/hazard_ctrl.sv
hazard_unit/trap_report.sv
source/pipe_ctrl_top.sv
test/pipe_ctrl_tb.sv

//--- test/pipe_ctrl_tb.sv
// pipeline control testbench, table of hazard scenarios checked against a queue model
`timescale 1ns/1ns

module pipe_ctrl_tb import pipe_ctrl_pkg::*; ();

    localparam int DEPTH = QUEUE_DEPTH_DEFAULT;

    // stimulus bits of a row, bits 9..0 in the order of the inputs they drive
    localparam logic [10:0] IDLE = 11'h000, DV = 11'h001, VSET = 11'h002, EB = 11'h004;
    localparam logic [10:0] JMP = 11'h008, BR = 11'h010, MISP = 11'h020, VDONE = 11'h040;
    localparam logic [10:0] MST = 11'h080, MLD = 11'h100, MBUSY = 11'h200;
    localparam logic [10:0] RD0 = 11'h400; // mem rd forced to x0, else head rs1
    // exception flags, highest priority first
    localparam logic [6:0] NO_EXC = 7'h00, FL = 7'h40, ML = 7'h20, FS = 7'h10;
    localparam logic [6:0] MS = 7'h08, ILL = 7'h04, BKP = 7'h02, ENV = 7'h01;
    // expected controls
    localparam logic [6:0] NO_CTRL = 7'h00, NPC = 7'h40, SD = 7'h20, FQ = 7'h10;
    localparam logic [6:0] SQ = 7'h08, EMS = 7'h04, EMF = 7'h02, SUP = 7'h01;

    logic        CLK, nRST;
    logic        dec_valid, dec_reg_write, dec_is_load, dec_is_csr_read, dec_is_vsetvl;
    word_t       dec_pc, ex_pc, m_pc;
    regidx_t     dec_rs1, dec_rs2, dec_rd, m_rd;
    vregidx_t    dec_vs1, dec_vs2, dec_vd;
    logic        dec_vs1_used, dec_vs2_used, dec_vreg_write;
    logic        ex_valid, ex_jump, ex_branch, ex_mispredict, ex_busy, ex_vsetvl_done;
    logic        m_valid, m_reg_write, m_dren, m_dwen, m_csr_read, d_mem_busy;
    logic        fault_l, mal_l, fault_s, mal_s, illegal_insn, breakpoint, env;
    logic        head_valid;
    word_t       head_pc, trap_epc;
    regidx_t     head_rs1, head_rs2, head_rd;
    logic        npc_sel, stall_decode, flush_queue, stall_queue;
    logic        ex_mem_stall, ex_mem_flush, suppress_data, trap_valid;
    trap_cause_t trap_cause;

    int          row_test [$];
    logic [10:0] row_stim [$];
    logic [6:0]  row_exc [$];
    logic [6:0]  row_exp [$];
    word_t       model_pc [$];  // expected queue contents, head first
    regidx_t     model_rs1 [$];
    regidx_t     model_rs2 [$];
    regidx_t     model_rd [$];
    int          errors, test_errors, tests_failed;
    bit          table_ready;
    string       test_name [7] = '{"reset", "fill and order", "load-use", "branch and jump",
                                   "dmem wait", "trap priority", "vsetvl stall"};
    string       ctrl_name [7] = '{"suppress_data", "ex_mem_flush", "ex_mem_stall",
                                   "stall_queue", "flush_queue", "stall_decode", "npc_sel"};

    pipe_ctrl_top #(.QUEUE_DEPTH(DEPTH)) DUT (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK; // 8 ns period
    end

    task automatic add_row(input int t, input logic [10:0] s, input logic [6:0] e,
                           input logic [6:0] x);
        row_test.push_back(t);
        row_stim.push_back(s);
        row_exc.push_back(e);
        row_exp.push_back(x);
    endtask

    task automatic apply(input logic [10:0] s, input logic [6:0] e);
        {d_mem_busy, m_dren, m_dwen, ex_vsetvl_done, ex_mispredict, ex_branch,
         ex_jump, ex_busy, dec_is_vsetvl, dec_valid} = s[9:0];
        dec_pc  = $urandom & 32'hffff_fffc;
        dec_rs1 = regidx_t'($urandom % 31 + 1); // nonzero so load-use can hit
        dec_rs2 = regidx_t'($urandom % 32);
        dec_rd  = regidx_t'($urandom % 32);
        dec_reg_write = 1'b1;
        {dec_is_load, dec_is_csr_read, m_csr_read} = '0;
        {dec_vs1, dec_vs2, dec_vd, dec_vs1_used, dec_vs2_used, dec_vreg_write} = '0;
        ex_pc    = $urandom & 32'hffff_fffc;
        ex_valid = ex_jump || ex_branch;
        m_pc     = $urandom & 32'hffff_fffc;
        m_valid  = m_dren || m_dwen;
        m_reg_write = m_dren;                   // loads write rd, stores not
        if ((s & RD0) != 0) m_rd = '0;
        else if (model_rs1.size() != 0) m_rd = model_rs1[0];
        else m_rd = regidx_t'($urandom % 31 + 1);
        {fault_l, mal_l, fault_s, mal_s, illegal_insn, breakpoint, env} = e;
    endtask

    task automatic compare(input int row, input string name, input logic [31:0] got,
                           input logic [31:0] want);
        if (got !== want) begin
            $display("Mismatch %s: got %h, expected %h (row %0d)", name, got, want, row);
            errors++;
            test_errors++;
        end
    endtask

    // queue behaviour at the clock edge, flush beats pop and push
    task automatic update_model(input logic [6:0] x);
        bit room;
        room = model_pc.size() < DEPTH;
        if ((x & FQ) != 0) begin
            model_pc.delete();
            model_rs1.delete();
            model_rs2.delete();
            model_rd.delete();
        end else begin
            if (model_pc.size() != 0 && (x & SQ) == 0) begin
                void'(model_pc.pop_front());
                void'(model_rs1.pop_front());
                void'(model_rs2.pop_front());
                void'(model_rd.pop_front());
            end
            if (dec_valid && (x & SD) == 0 && room) begin
                model_pc.push_back(dec_pc);
                model_rs1.push_back(dec_rs1);
                model_rs2.push_back(dec_rs2);
                model_rd.push_back(dec_rd);
            end
        end
    endtask

    // load fault, load misaligned, store fault, store misaligned, illegal, ebreak, ecall
    function automatic trap_cause_t expected_cause(input logic [6:0] f);
        if (f[6]) return cause_fault_load;
        if (f[5]) return cause_mal_load;
        if (f[4]) return cause_fault_store;
        if (f[3]) return cause_mal_store;
        if (f[2]) return cause_illegal;
        if (f[1]) return cause_breakpoint;
        if (f[0]) return cause_env_call;
        return cause_none;
    endfunction

    task automatic end_test(input int t);
        if (test_errors != 0) tests_failed++;
        $display("test %0d %s: %0d errors", t, test_name[t], test_errors);
        test_errors = 0;
    endtask

    task automatic build_table();
        repeat (DEPTH) add_row(1, DV | EB, NO_EXC, SQ | EMF);  // fill, busy execute
        add_row(1, DV | EB, NO_EXC, SD | SQ | EMF);            // full, write refused
        add_row(1, IDLE, NO_EXC, SD);                          // still full as head pops
        repeat (DEPTH - 1) add_row(1, IDLE, NO_EXC, NO_CTRL);  // drain in order
        add_row(2, DV | EB, NO_EXC, SQ | EMF);
        add_row(2, MLD, NO_EXC, SQ | EMF);                     // load to head rs1
        add_row(2, MLD | RD0, NO_EXC, NO_CTRL);                // x0 never stalls
        add_row(3, DV | EB, NO_EXC, SQ | EMF);
        add_row(3, JMP, NO_EXC, NPC | FQ | EMF);
        add_row(3, DV | EB, NO_EXC, SQ | EMF);
        add_row(3, BR | MISP, NO_EXC, NPC | FQ | EMF);
        add_row(3, DV | EB, NO_EXC, SQ | EMF);
        add_row(3, BR | EB, NO_EXC, SQ | EMF);                 // predicted right
        add_row(3, IDLE, NO_EXC, NO_CTRL);
        add_row(4, DV | EB, NO_EXC, SQ | EMF);
        add_row(4, MLD | MBUSY | RD0, NO_EXC, SQ | EMS);
        add_row(4, MST | MBUSY, NO_EXC, SQ | EMS);
        add_row(4, MST | MBUSY, FS, FQ | EMF | SUP);           // faulting store not waited on
        add_row(4, IDLE, NO_EXC, NO_CTRL);
        add_row(5, IDLE, ILL | BKP | ENV, FQ | EMF | SUP);
        add_row(5, IDLE, ML | FS | ENV, FQ | EMF | SUP);
        add_row(5, IDLE, FL | ML | FS | MS | ILL | BKP | ENV, FQ | EMF | SUP);
        add_row(5, IDLE, BKP | ENV, FQ | EMF | SUP);
        add_row(5, IDLE, MS | ILL, FQ | EMF | SUP);
        add_row(5, IDLE, ENV, FQ | EMF | SUP);
        add_row(5, IDLE, NO_EXC, NO_CTRL);
        add_row(6, DV | VSET | EB, NO_EXC, SQ | EMF);
        add_row(6, DV | EB, NO_EXC, SD | SQ | EMF);
        add_row(6, DV | EB | VDONE, NO_EXC, SD | SQ | EMF);    // clears at this edge
        add_row(6, DV | EB, NO_EXC, SQ | EMF);
        add_row(6, DV | VSET | EB, NO_EXC, SQ | EMF);
        add_row(6, DV | EB, NO_EXC, SD | SQ | EMF);
        add_row(6, DV | JMP, NO_EXC, NPC | FQ | EMF);          // redirect squashes vsetvl
        add_row(6, DV, NO_EXC, NO_CTRL);
        add_row(6, IDLE, NO_EXC, NO_CTRL);
    endtask

    initial begin
        wait (table_ready);
        #((row_test.size() + 20) * 8);
        $display("timeout, rows did not complete within the expected time");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        logic [6:0] x;
        logic [6:0] e;
        logic [6:0] ctrl;
        word_t      epc_want;
        void'($urandom(32'hc6e09f4a));
        errors = 0;
        test_errors = 0;
        tests_failed = 0;
        build_table();
        table_ready = 1'b1;
        nRST = 1'b0;
        apply(IDLE, NO_EXC);
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        compare(-1, "head_valid", 32'(head_valid), 32'h0);
        compare(-1, "trap_valid", 32'(trap_valid), 32'h0);
        compare(-1, "stall_decode", 32'(stall_decode), 32'h0);
        end_test(0);
        nRST = 1'b1;
        for (int i = 0; i < row_test.size(); i++) begin
            x = row_exp[i];
            e = row_exc[i];
            apply(row_stim[i], e);
            #2; // controls are combinational, settle well before the edge
            ctrl = {npc_sel, stall_decode, flush_queue, stall_queue,
                    ex_mem_stall, ex_mem_flush, suppress_data};
            for (int b = 0; b < 7; b++) compare(i, ctrl_name[b], 32'(ctrl[b]), 32'(x[b]));
            epc_want = (e[6:3] != 0) ? m_pc : ex_pc; // memory causes point at mem pc
            update_model(x);
            @(negedge CLK);
            compare(i, "head_valid", 32'(head_valid), 32'(model_pc.size() != 0));
            if (model_pc.size() != 0) begin
                compare(i, "head_pc", head_pc, model_pc[0]);
                compare(i, "head_rs1", 32'(head_rs1), 32'(model_rs1[0]));
                compare(i, "head_rs2", 32'(head_rs2), 32'(model_rs2[0]));
                compare(i, "head_rd", 32'(head_rd), 32'(model_rd[0]));
            end
            compare(i, "trap_valid", 32'(trap_valid), 32'(e != 0));
            compare(i, "trap_cause", 32'(trap_cause), 32'(expected_cause(e)));
            if (e != 0) compare(i, "trap_epc", trap_epc, epc_want);
            if (i + 1 == row_test.size() || row_test[i + 1] != row_test[i])
                end_test(row_test[i]);
        end
        $display("7 tests, %0d failed, %0d errors over %0d rows",
                 tests_failed, errors, row_test.size());
        if (errors == 0) $display("*** TEST PASSED ***");
        else $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
